//--- verilog/pll_pkg.sv
package pll_pkg;

    localparam int PHASE_W = 12;                   // accumulator width

    typedef logic [PHASE_W-1:0] tune_t;            // unsigned tuning word
    typedef logic signed [7:0] err_t;              // phase error in clock cycles
    typedef logic signed [PHASE_W-1:0] corr_t;     // frequency correction
    typedef logic [3:0] nibble_t;
    typedef logic [7:0] seg_t;                     // active low, dp + g..a

    typedef struct packed {
        err_t error;
        logic valid;                               // one-cycle pulse per sample
    } pd_result_t;

    typedef struct packed {
        logic [7:0] digit;                         // active-low digit enables
        seg_t       segment;
    } disp_t;

    typedef enum logic [1:0] {
        IDLE,
        REF_LEAD,
        GEN_LEAD
    } pd_state_t;

    localparam seg_t SEG_BLANK = 8'hFF;            // all segments dark
    localparam seg_t SEG_MINUS = 8'hBF;            // segment g only

    // hex glyphs, lit segments listed as g..a before inversion
    function automatic seg_t seg_of(input nibble_t nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};                       // dp stays off
    endfunction

endpackage

//--- verilog/phase_accum.sv
`timescale 1ns/1ps

module phase_accum (
    input  logic           fpga_clk_i,
    input  logic           reset_i,
    input  pll_pkg::tune_t tune_i,
    output logic           clk_o
);

    logic [pll_pkg::PHASE_W-1:0] acc;

    // wraps k times per 4096 cycles
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            acc <= '0;
        end else begin
            acc <= acc + tune_i;
        end
    end

    assign clk_o = acc[pll_pkg::PHASE_W-1];        // msb is the square wave

endmodule

//--- verilog/phase_detector.sv
`timescale 1ns/1ps

module phase_detector (
    input  logic                fpga_clk_i,
    input  logic                reset_i,
    input  logic                ref_clk_i,
    input  logic                gen_clk_i,
    output pll_pkg::pd_result_t result_o
);

    logic [1:0]         ref_sr;                    // [0] input reg, [1] previous
    logic [1:0]         gen_sr;
    logic               ref_rise;
    logic               gen_rise;
    pll_pkg::pd_state_t state;
    logic [6:0]         count;                     // cycles since leading edge
    logic               done;
    pll_pkg::err_t      err_next;
    logic               valid_q;
    pll_pkg::err_t      error_q;

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            ref_sr <= '0;
            gen_sr <= '0;
        end else begin
            ref_sr <= {ref_sr[0], ref_clk_i};
            gen_sr <= {gen_sr[0], gen_clk_i};
        end
    end

    assign ref_rise = ref_sr[0] & ~ref_sr[1];
    assign gen_rise = gen_sr[0] & ~gen_sr[1];

    // closing edge ends the measurement
    always_comb begin
        done     = 1'b0;
        err_next = '0;
        case (state)
            pll_pkg::IDLE: done = ref_rise & gen_rise;  // coincident, error 0
            pll_pkg::REF_LEAD: begin
                done     = gen_rise;
                err_next = pll_pkg::err_t'({1'b0, count});   // gen is late
            end
            pll_pkg::GEN_LEAD: begin
                done     = ref_rise;
                err_next = -pll_pkg::err_t'({1'b0, count});
            end
            default: done = 1'b0;
        endcase
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            state <= pll_pkg::IDLE;
            count <= '0;
        end else begin
            case (state)
                pll_pkg::IDLE: begin
                    if (ref_rise && !gen_rise) begin
                        state <= pll_pkg::REF_LEAD;
                        count <= 7'd1;
                    end else if (gen_rise && !ref_rise) begin
                        state <= pll_pkg::GEN_LEAD;
                        count <= 7'd1;
                    end
                end
                pll_pkg::REF_LEAD, pll_pkg::GEN_LEAD: begin
                    if (done) begin
                        state <= pll_pkg::IDLE;
                    end else if (count != '1) begin   // stick at 127
                        count <= count + 7'd1;
                    end
                end
                default: state <= pll_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= done;
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (done) begin
            error_q <= err_next;
        end
    end

    assign result_o = '{error: error_q, valid: valid_q};

endmodule

//--- verilog/loop_filter.sv
`timescale 1ns/1ps

module loop_filter #(
    parameter int KP_SHIFT   = 2,
    parameter int KI_SHIFT   = 4,
    parameter int CORR_LIMIT = 64
) (
    input  logic                fpga_clk_i,
    input  logic                reset_i,
    input  pll_pkg::pd_result_t result_i,
    output pll_pkg::corr_t      corr_o,
    output pll_pkg::err_t       error_o
);

    localparam int INT_W     = pll_pkg::PHASE_W + KI_SHIFT + 1;
    localparam int INT_LIMIT = CORR_LIMIT << KI_SHIFT;  // integral term within corr limit

    logic signed [INT_W-1:0] integral;
    logic signed [INT_W-1:0] err_ext;
    logic signed [INT_W-1:0] int_sum;
    logic signed [INT_W-1:0] int_next;
    logic signed [INT_W-1:0] corr_sum;
    pll_pkg::corr_t          corr_next;
    pll_pkg::corr_t          corr_q;
    pll_pkg::err_t           err_q;

    always_comb begin
        err_ext = INT_W'(result_i.error);              // sign extended
        int_sum = integral + err_ext;
        if (int_sum > INT_LIMIT) begin
            int_next = INT_W'(INT_LIMIT);
        end else if (int_sum < -INT_LIMIT) begin
            int_next = INT_W'(-INT_LIMIT);
        end else begin
            int_next = int_sum;
        end
        corr_sum = (err_ext >>> KP_SHIFT) + (int_next >>> KI_SHIFT);
        if (corr_sum > CORR_LIMIT) begin
            corr_next = pll_pkg::corr_t'(CORR_LIMIT);
        end else if (corr_sum < -CORR_LIMIT) begin
            corr_next = pll_pkg::corr_t'(-CORR_LIMIT);
        end else begin
            corr_next = pll_pkg::corr_t'(corr_sum);
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            integral <= '0;
            corr_q   <= '0;
            err_q    <= '0;
        end else if (result_i.valid) begin
            integral <= int_next;
            corr_q   <= corr_next;
            err_q    <= result_i.error;            // held for the display
        end
    end

    assign corr_o  = corr_q;
    assign error_o = err_q;

endmodule

//--- verilog/digital_osc.sv
`timescale 1ns/1ps

module digital_osc #(
    parameter pll_pkg::tune_t NOMINAL_K = 256
) (
    input  logic           fpga_clk_i,
    input  logic           reset_i,
    input  pll_pkg::corr_t corr_i,
    output logic           gen_clk_o
);

    localparam int SUM_W  = pll_pkg::PHASE_W + 2;
    localparam int K_MAX  = (2 ** pll_pkg::PHASE_W) - 1;

    logic signed [SUM_W-1:0] sum;
    pll_pkg::tune_t          word;

    assign sum = $signed({2'b00, NOMINAL_K}) + SUM_W'(corr_i);

    // tuning word follows the correction one cycle later
    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            word <= NOMINAL_K;
        end else if (sum < 1) begin
            word <= pll_pkg::tune_t'(1);           // never stall
        end else if (sum > K_MAX) begin
            word <= '1;
        end else begin
            word <= pll_pkg::tune_t'(sum);
        end
    end

    phase_accum dco_acc (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .tune_i     (word),
        .clk_o      (gen_clk_o)
    );

endmodule

//--- verilog/error_display.sv
`timescale 1ns/1ps

module error_display #(
    parameter int SCAN_BITS = 4
) (
    input  logic           fpga_clk_i,
    input  logic           reset_i,
    input  pll_pkg::err_t  error_i,
    output pll_pkg::disp_t disp_o
);

    logic [SCAN_BITS+1:0] scan_cnt;                // top two bits pick the digit
    logic [1:0]           sel;
    logic                 neg;
    logic [7:0]           mag;                     // -128 comes out as 8'h80
    pll_pkg::seg_t        seg_next;
    pll_pkg::disp_t       disp_q;

    assign sel = scan_cnt[SCAN_BITS+1 -: 2];
    assign neg = error_i < 0;
    assign mag = neg ? 8'(-error_i) : 8'(error_i);

    always_comb begin
        case (sel)
            2'd0: seg_next = pll_pkg::seg_of(mag[3:0]);
            2'd1: seg_next = pll_pkg::seg_of(mag[7:4]);
            2'd2: seg_next = pll_pkg::SEG_BLANK;
            default: seg_next = neg ? pll_pkg::SEG_MINUS : pll_pkg::SEG_BLANK;
        endcase
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            scan_cnt <= '0;
            disp_q   <= '{digit: 8'hFF, segment: pll_pkg::SEG_BLANK};
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
            disp_q   <= '{digit: ~(8'd1 << sel), segment: seg_next};
        end
    end

    assign disp_o = disp_q;

endmodule

//--- verilog/lock_range_top.sv
`timescale 1ns/1ps

module lock_range_top #(
    parameter pll_pkg::tune_t NOMINAL_K  = 256,
    parameter int             CORR_LIMIT = 64,
    parameter int             KP_SHIFT   = 2,
    parameter int             KI_SHIFT   = 4,
    parameter int             SCAN_BITS  = 4
) (
    input  logic           fpga_clk_i,
    input  logic           reset_i,
    input  pll_pkg::tune_t k_val_i,
    output logic           ref_clk_o,
    output logic           gen_clk_o,
    output pll_pkg::err_t  error_o,
    output logic [7:0]     digit_o,
    output pll_pkg::seg_t  segment_o
);

    logic                ref_clk;
    logic                gen_clk;
    pll_pkg::pd_result_t pd_result;
    pll_pkg::corr_t      corr;
    pll_pkg::err_t       error;
    pll_pkg::disp_t      disp;

    phase_accum ref_osc (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .tune_i     (k_val_i),
        .clk_o      (ref_clk)
    );

    phase_detector pd (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .ref_clk_i  (ref_clk),
        .gen_clk_i  (gen_clk),
        .result_o   (pd_result)
    );

    loop_filter #(
        .KP_SHIFT   (KP_SHIFT),
        .KI_SHIFT   (KI_SHIFT),
        .CORR_LIMIT (CORR_LIMIT)
    ) lf (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .result_i   (pd_result),
        .corr_o     (corr),
        .error_o    (error)
    );

    digital_osc #(.NOMINAL_K(NOMINAL_K)) dco (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .corr_i     (corr),
        .gen_clk_o  (gen_clk)
    );

    error_display #(.SCAN_BITS(SCAN_BITS)) disp_drv (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .error_i    (error),
        .disp_o     (disp)
    );

    assign ref_clk_o = ref_clk;
    assign gen_clk_o = gen_clk;
    assign error_o   = error;
    assign digit_o   = disp.digit;
    assign segment_o = disp.segment;

endmodule

//--- test/lock_range_tb.sv
`timescale 1ns/1ps

module lock_range_tb;

    localparam int NOMINAL_K  = 256;
    localparam int CORR_LIMIT = 64;
    localparam int SETTLE     = 40000;             // cycles before measuring
    localparam int WINDOW     = 4096;              // one full accumulator wrap

    // lit segments g..a for each hex glyph
    localparam logic [6:0] GLYPH [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    typedef struct packed {
        pll_pkg::tune_t k;
        logic           lock;                      // loop expected to lock
        pll_pkg::tune_t freq;                      // expected gen edges per window
    } row_t;

    logic           fpga_clk;
    logic           reset;
    pll_pkg::tune_t k_val;
    logic           ref_clk;
    logic           gen_clk;
    pll_pkg::err_t  error;
    logic [7:0]     digit;
    pll_pkg::seg_t  segment;

    row_t           rows[$];
    string          names[$];
    integer         seed;

    lock_range_top #(
        .NOMINAL_K  (NOMINAL_K),
        .CORR_LIMIT (CORR_LIMIT),
        .KP_SHIFT   (2),
        .KI_SHIFT   (4),
        .SCAN_BITS  (4)
    ) dut_i (
        .fpga_clk_i (fpga_clk),
        .reset_i    (reset),
        .k_val_i    (k_val),
        .ref_clk_o  (ref_clk),
        .gen_clk_o  (gen_clk),
        .error_o    (error),
        .digit_o    (digit),
        .segment_o  (segment)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #50 fpga_clk = ~fpga_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // counts that may be off by one edge
    function automatic int within_one(input int expected, input int actual);
        return (actual >= expected - 1 && actual <= expected + 1) ? expected : actual;
    endfunction

    function automatic pll_pkg::seg_t expected_seg(input pll_pkg::err_t err, input int pos);
        int         e;
        int         m;
        logic [6:0] lit;
        e = err;
        m = (e < 0) ? -e : e;                      // -128 gives 128, shown as 80
        case (pos)
            0: lit = GLYPH[m % 16];
            1: lit = GLYPH[m / 16];
            2: lit = 7'h00;
            default: lit = (e < 0) ? 7'h40 : 7'h00;   // minus sign is segment g
        endcase
        return {1'b1, ~lit};
    endfunction

    task automatic next_cycle();
        @(posedge fpga_clk);
        #1;                                        // drive and sample after the edge
    endtask

    task automatic add_row(input string name, input int k, input logic lock, input int freq);
        rows.push_back('{k: pll_pkg::tune_t'(k), lock: lock, freq: pll_pkg::tune_t'(freq)});
        names.push_back(name);
    endtask

    task automatic apply_reset(input string name, input pll_pkg::tune_t k);
        int i;
        k_val = k;
        reset = 1'b1;
        for (i = 0; i < 4; i++) begin
            if (i == 3) begin
                reset = 1'b0;                      // last pass is the first free cycle
            end
            next_cycle();
            check({name, " reset error_o"}, 0, error);
            check({name, " reset ref_clk_o"}, 0, ref_clk);
            check({name, " reset gen_clk_o"}, 0, gen_clk);
            if (i < 3) begin
                check({name, " reset segments"}, 8'hFF, segment);
            end else begin
                check({name, " reset digit 3 enable"}, 1, digit[3]);   // digit 3 still dark
            end
        end
    endtask

    task automatic wait_ref_rise(input string name);
        int   n;
        logic was;
        n   = 0;
        was = ref_clk;
        next_cycle();
        while (!(ref_clk && !was)) begin
            if (n == WINDOW) begin
                abort_run($sformatf("%s: no rising edge on ref_clk_o within %0d cycles",
                                    name, WINDOW));
            end else begin
                was = ref_clk;
                next_cycle();
                n++;
            end
        end
    endtask

    task automatic check_digit(input string name, input pll_pkg::err_t err_seen);
        int pos;
        case (digit)
            8'hFE: pos = 0;
            8'hFD: pos = 1;
            8'hFB: pos = 2;
            8'hF7: pos = 3;
            default: pos = -1;
        endcase
        if (pos < 0) begin
            abort_run($sformatf("%s: digit enables %02h do not select one of the four digits",
                                name, digit));
        end else begin
            check($sformatf("%s digit %0d segments", name, pos),
                  expected_seg(err_seen, pos), segment);
        end
    endtask

    task automatic run_row(input string name, input row_t row);
        int            cyc;
        int            ref_edges;
        int            gen_edges;
        int            abs_err;
        int            peak;
        logic          ref_prev;
        logic          gen_prev;
        logic [7:0]    digit_prev;
        pll_pkg::err_t err_prev;
        apply_reset(name, row.k);
        repeat (SETTLE) next_cycle();
        wait_ref_rise(name);
        ref_edges  = 0;
        gen_edges  = 0;
        peak       = 0;
        ref_prev   = ref_clk;
        gen_prev   = gen_clk;
        digit_prev = digit;
        err_prev   = error;
        for (cyc = 0; cyc < WINDOW; cyc++) begin
            next_cycle();
            if (ref_clk && !ref_prev) ref_edges++;
            if (gen_clk && !gen_prev) gen_edges++;
            abs_err = (error < 0) ? -int'(error) : int'(error);
            if (abs_err > peak) peak = abs_err;
            if (digit != digit_prev) check_digit(name, err_prev);   // display lags one cycle
            ref_prev   = ref_clk;
            gen_prev   = gen_clk;
            digit_prev = digit;
            err_prev   = error;
        end
        check({name, " ref edges"}, row.k, within_one(row.k, ref_edges));
        if (row.lock) begin
            check({name, " gen edges"}, ref_edges, within_one(ref_edges, gen_edges));
            check({name, " peak |error_o|"}, 15, (peak < 16) ? 15 : peak);
        end else begin
            check({name, " clamped gen edges"}, row.freq, within_one(row.freq, gen_edges));
        end
    endtask

    initial begin
        int             r;
        pll_pkg::tune_t k;
        reset = 1'b1;
        k_val = '0;
        seed  = 38642;
        add_row("center", 256, 1'b1, 256);
        add_row("low_in", 208, 1'b1, 208);
        add_row("high_in", 300, 1'b1, 300);
        add_row("near_low", 200, 1'b1, 200);
        add_row("near_high", 312, 1'b1, 312);
        add_row("below", 150, 1'b0, NOMINAL_K - CORR_LIMIT);
        add_row("above", 400, 1'b0, NOMINAL_K + CORR_LIMIT);
        for (r = 0; r < 3; r++) begin
            k = pll_pkg::tune_t'(NOMINAL_K + ($random(seed) % (CORR_LIMIT - 15)));
            add_row($sformatf("random%0d", r), k, 1'b1, k);
        end
        for (r = 0; r < rows.size(); r++) begin
            run_row(names[r], rows[r]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- sources.f
verilog/pll_pkg.sv
verilog/phase_accum.sv
verilog/phase_detector.sv
verilog/loop_filter.sv
verilog/digital_osc.sv
verilog/error_display.sv
verilog/lock_range_top.sv
test/lock_range_tb.sv

//--- Makefile
SRCS := $(shell cat sources.f)

obj_dir/Vlock_range_tb: sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal -f sources.f --top-module lock_range_tb

run: obj_dir/Vlock_range_tb
	@out=$$(./obj_dir/Vlock_range_tb); echo "$$out"; echo "$$out" | grep -q '>>> PASS'

clean:
	rm -rf obj_dir

.PHONY: run clean
